//--- design/cdb_pkg.sv
`default_nettype none

package cdb_pkg;

    // ==============================
    // Machine geometry
    // ==============================

    localparam int NUM_WARPS = 8;
    localparam int WARP_W    = 3;

    localparam int NUM_LANES = 8;
    localparam int LANE_W    = 32;
    localparam int DATA_W    = NUM_LANES * LANE_W;

    localparam int NUM_REGS  = 8;
    localparam int REG_W     = 3;

    // The execution units carry the full 5-bit destination field of the ISA.
    localparam int DST_W     = 5;

    localparam int SCB_ENTRIES = 4;
    localparam int SCB_W       = 2;

    localparam int INSTR_W = 32;

    // ==============================
    // Arbitration
    // ==============================

    // Collisions MEM may lose in a row before it is given the bus.
    localparam int STARVE_LIMIT = 3;
    localparam int CNT_W        = 2;

    typedef enum logic [0:0] {
        GRANT_ALU_FIRST,
        GRANT_MEM_FORCED
    } grant_state_e;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_ALU,
        SRC_MEM
    } cdb_src_e;

endpackage

`default_nettype wire

//--- design/cdb_grant_fsm.sv
`default_nettype none

module cdb_grant_fsm (
    input  wire                clk,
    input  wire                reset,
    input  wire                alu_valid,
    input  wire                mem_valid,
    input  wire                starve_hit,
    output cdb_pkg::cdb_src_e  grant,
    output logic               alu_stall,
    output logic               mem_stall
);

    import cdb_pkg::*;

    grant_state_e state;
    grant_state_e state_next;
    logic         collide;

    assign collide = alu_valid && mem_valid;

    // ALU wins a collision unless MEM has been pushed back too often.
    always_comb
    begin
        if (collide)
            grant = (state == GRANT_MEM_FORCED) ? SRC_MEM : SRC_ALU;
        else if (alu_valid)
            grant = SRC_ALU;
        else if (mem_valid)
            grant = SRC_MEM;
        else
            grant = SRC_NONE;
    end

    // Only the loser of a collision is held.
    assign alu_stall = collide && (grant == SRC_MEM);
    assign mem_stall = collide && (grant == SRC_ALU);

    always_comb
    begin
        state_next = state;
        case (state)
            GRANT_ALU_FIRST:
            begin
                if (starve_hit)
                    state_next = GRANT_MEM_FORCED;
            end
            GRANT_MEM_FORCED:
            begin
                if (grant == SRC_MEM)
                    state_next = GRANT_ALU_FIRST;
            end
            default: state_next = GRANT_ALU_FIRST;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= GRANT_ALU_FIRST;
        else
            state <= state_next;
    end

    assert property (@(posedge clk) disable iff (reset)
        !(alu_stall && mem_stall));

    assert property (@(posedge clk) disable iff (reset)
        (!alu_stall || alu_valid) && (!mem_stall || mem_valid));

    // A held MEM result must still be offered on the next cycle.
    assert property (@(posedge clk) disable iff (reset)
        mem_stall |=> mem_valid);

endmodule

`default_nettype wire

//--- design/starve_counter.sv
`default_nettype none

module starve_counter (
    input  wire                clk,
    input  wire                reset,
    input  wire                alu_valid,
    input  wire                mem_valid,
    input  var cdb_pkg::cdb_src_e grant,
    output logic               starve_hit
);

    import cdb_pkg::*;

    logic [CNT_W-1:0] count;
    logic             lost;

    // MEM loses when both units compete and ALU takes the bus.
    assign lost = alu_valid && mem_valid && (grant == SRC_ALU);

    // Flags the loss that brings the count up to the limit, so the FSM
    // is forced on the same edge as the count gets there.
    assign starve_hit = lost && (count == CNT_W'(STARVE_LIMIT - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (grant == SRC_MEM)
            count <= '0;
        else if (lost)
            count <= count + 1'b1;
    end

    // At the limit the grant FSM has to hand the next collision to MEM.
    assert property (@(posedge clk) disable iff (reset)
        (count == CNT_W'(STARVE_LIMIT)) |-> !lost);

endmodule

`default_nettype wire

//--- design/cdb_select.sv
`default_nettype none

module cdb_select (
    input  wire                              clk,
    input  wire                              reset,
    input  var cdb_pkg::cdb_src_e            grant,
    input  wire [cdb_pkg::WARP_W-1:0]        alu_warp,
    input  wire [cdb_pkg::DST_W-1:0]         alu_dst,
    input  wire [cdb_pkg::DATA_W-1:0]        alu_data,
    input  wire [cdb_pkg::INSTR_W-1:0]       alu_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]     alu_mask,
    input  wire [cdb_pkg::SCB_W-1:0]         alu_scb_id,
    input  wire [cdb_pkg::WARP_W-1:0]        mem_warp,
    input  wire [cdb_pkg::DST_W-1:0]         mem_dst,
    input  wire [cdb_pkg::DATA_W-1:0]        mem_data,
    input  wire [cdb_pkg::INSTR_W-1:0]       mem_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]     mem_mask,
    input  wire [cdb_pkg::SCB_W-1:0]         mem_scb_id,
    output logic                             cdb_valid,
    output logic [cdb_pkg::WARP_W-1:0]       cdb_warp,
    output logic [cdb_pkg::REG_W-1:0]        cdb_addr,
    output logic [cdb_pkg::DATA_W-1:0]       cdb_data,
    output logic [cdb_pkg::INSTR_W-1:0]      cdb_instr,
    output logic [cdb_pkg::NUM_LANES-1:0]    cdb_mask,
    output logic [cdb_pkg::SCB_W-1:0]        cdb_scb_id
);

    import cdb_pkg::*;

    logic [WARP_W-1:0]    sel_warp;
    logic [REG_W-1:0]     sel_addr;
    logic [DATA_W-1:0]    sel_data;
    logic [INSTR_W-1:0]   sel_instr;
    logic [NUM_LANES-1:0] sel_mask;
    logic [SCB_W-1:0]     sel_scb_id;

    // Only the low bits of the destination address the per-warp file.
    always_comb
    begin
        case (grant)
            SRC_MEM:
            begin
                sel_warp   = mem_warp;
                sel_addr   = mem_dst[REG_W-1:0];
                sel_data   = mem_data;
                sel_instr  = mem_instr;
                sel_mask   = mem_mask;
                sel_scb_id = mem_scb_id;
            end
            default:
            begin
                sel_warp   = alu_warp;
                sel_addr   = alu_dst[REG_W-1:0];
                sel_data   = alu_data;
                sel_instr  = alu_instr;
                sel_mask   = alu_mask;
                sel_scb_id = alu_scb_id;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= (grant != SRC_NONE);
    end

    // The payload only moves when a unit owns the bus.
    always_ff @(posedge clk)
    begin
        if (grant != SRC_NONE)
        begin
            cdb_warp   <= sel_warp;
            cdb_addr   <= sel_addr;
            cdb_data   <= sel_data;
            cdb_instr  <= sel_instr;
            cdb_mask   <= sel_mask;
            cdb_scb_id <= sel_scb_id;
        end
    end

endmodule

`default_nettype wire

//--- design/warp_regfile.sv
`default_nettype none

module warp_regfile (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cdb_valid,
    input  wire [cdb_pkg::WARP_W-1:0]      cdb_warp,
    input  wire [cdb_pkg::REG_W-1:0]       cdb_addr,
    input  wire [cdb_pkg::DATA_W-1:0]      cdb_data,
    input  wire [cdb_pkg::NUM_LANES-1:0]   cdb_mask,
    input  wire [cdb_pkg::WARP_W-1:0]      rd_warp,
    input  wire [cdb_pkg::REG_W-1:0]       rd_addr,
    output logic [cdb_pkg::DATA_W-1:0]     rd_data
);

    import cdb_pkg::*;

    localparam int DEPTH = NUM_WARPS * NUM_REGS;

    // ==============================
    // Storage
    // ==============================

    // One row per warp and register, lanes packed low lane first.
    logic [DATA_W-1:0] regs [DEPTH];

    logic [WARP_W+REG_W-1:0] wr_idx;
    logic [WARP_W+REG_W-1:0] rd_idx;

    assign wr_idx = {cdb_warp, cdb_addr};
    assign rd_idx = {rd_warp, rd_addr};

    // Inactive lanes keep their old value.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int r = 0; r < DEPTH; r++)
                regs[r] <= '0;
        end
        else if (cdb_valid)
        begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
                if (cdb_mask[l])
                    regs[wr_idx][l*LANE_W +: LANE_W] <= cdb_data[l*LANE_W +: LANE_W];
            end
        end
    end

    // ==============================
    // Read port
    // ==============================

    assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

//--- design/warp_scoreboard.sv
`default_nettype none

module warp_scoreboard (
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire                                            issue_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                      issue_warp,
    input  wire [cdb_pkg::REG_W-1:0]                       issue_dst,
    input  wire [cdb_pkg::SCB_W-1:0]                       issue_scb_id,
    input  wire                                            cdb_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                      cdb_warp,
    input  wire [cdb_pkg::SCB_W-1:0]                       cdb_scb_id,
    output logic                                           issue_hazard,
    output logic [cdb_pkg::NUM_WARPS*cdb_pkg::SCB_ENTRIES-1:0] scb_busy
);

    import cdb_pkg::*;

    localparam int TOTAL = NUM_WARPS * SCB_ENTRIES;

    // Destination register of every pending write.
    logic [REG_W-1:0] ent_dst [TOTAL];

    logic [WARP_W+SCB_W-1:0] rsv_idx;
    logic [WARP_W+SCB_W-1:0] clr_idx;

    assign rsv_idx = {issue_warp, issue_scb_id};
    assign clr_idx = {cdb_warp, cdb_scb_id};

    // A reserve issued on the same edge as a clear of that entry wins.
    always_ff @(posedge clk)
    begin
        if (reset)
            scb_busy <= '0;
        else
        begin
            if (cdb_valid)
                scb_busy[clr_idx] <= 1'b0;
            if (issue_valid)
                scb_busy[rsv_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue_valid)
            ent_dst[rsv_idx] <= issue_dst;
    end

    // Check the new destination against every pending write of the warp.
    always_comb
    begin
        issue_hazard = 1'b0;
        for (int e = 0; e < SCB_ENTRIES; e++)
        begin
            if (issue_valid
                && scb_busy[{issue_warp, SCB_W'(e)}]
                && (ent_dst[{issue_warp, SCB_W'(e)}] == issue_dst))
                issue_hazard = 1'b1;
        end
    end

    // Issue must pick a free entry unless the CDB frees it right now.
    assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !(cdb_valid && (clr_idx == rsv_idx))) |-> !scb_busy[rsv_idx]);

    // Every broadcast has to name an entry that was reserved at issue.
    assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> scb_busy[clr_idx]);

endmodule

`default_nettype wire

//--- design/writeback_top.sv
`default_nettype none

module writeback_top (
    input  wire                                            clk,
    input  wire                                            reset,

    input  wire                                            alu_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                      alu_warp,
    input  wire [cdb_pkg::DST_W-1:0]                       alu_dst,
    input  wire [cdb_pkg::DATA_W-1:0]                      alu_data,
    input  wire [cdb_pkg::INSTR_W-1:0]                     alu_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]                   alu_mask,
    input  wire [cdb_pkg::SCB_W-1:0]                       alu_scb_id,

    input  wire                                            mem_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                      mem_warp,
    input  wire [cdb_pkg::DST_W-1:0]                       mem_dst,
    input  wire [cdb_pkg::DATA_W-1:0]                      mem_data,
    input  wire [cdb_pkg::INSTR_W-1:0]                     mem_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]                   mem_mask,
    input  wire [cdb_pkg::SCB_W-1:0]                       mem_scb_id,

    input  wire                                            issue_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                      issue_warp,
    input  wire [cdb_pkg::REG_W-1:0]                       issue_dst,
    input  wire [cdb_pkg::SCB_W-1:0]                       issue_scb_id,

    input  wire [cdb_pkg::WARP_W-1:0]                      rd_warp,
    input  wire [cdb_pkg::REG_W-1:0]                       rd_addr,
    output logic [cdb_pkg::DATA_W-1:0]                     rd_data,

    output logic                                           cdb_valid,
    output logic [cdb_pkg::WARP_W-1:0]                     cdb_warp,
    output logic [cdb_pkg::REG_W-1:0]                      cdb_addr,
    output logic [cdb_pkg::DATA_W-1:0]                     cdb_data,
    output logic [cdb_pkg::INSTR_W-1:0]                    cdb_instr,
    output logic [cdb_pkg::NUM_LANES-1:0]                  cdb_mask,
    output logic [cdb_pkg::SCB_W-1:0]                      cdb_scb_id,

    output logic                                           alu_stall,
    output logic                                           mem_stall,
    output logic                                           issue_hazard,
    output logic [cdb_pkg::NUM_WARPS*cdb_pkg::SCB_ENTRIES-1:0] scb_busy
);

    import cdb_pkg::*;

    cdb_src_e grant;
    logic     starve_hit;

    // ==============================
    // Arbitration
    // ==============================

    cdb_grant_fsm i_grant_fsm (
        .clk        (clk),
        .reset      (reset),
        .alu_valid  (alu_valid),
        .mem_valid  (mem_valid),
        .starve_hit (starve_hit),
        .grant      (grant),
        .alu_stall  (alu_stall),
        .mem_stall  (mem_stall)
    );

    starve_counter i_starve_counter (
        .clk        (clk),
        .reset      (reset),
        .alu_valid  (alu_valid),
        .mem_valid  (mem_valid),
        .grant      (grant),
        .starve_hit (starve_hit)
    );

    // ==============================
    // Bus and its consumers
    // ==============================

    cdb_select i_cdb_select (
        .clk        (clk),
        .reset      (reset),
        .grant      (grant),
        .alu_warp   (alu_warp),
        .alu_dst    (alu_dst),
        .alu_data   (alu_data),
        .alu_instr  (alu_instr),
        .alu_mask   (alu_mask),
        .alu_scb_id (alu_scb_id),
        .mem_warp   (mem_warp),
        .mem_dst    (mem_dst),
        .mem_data   (mem_data),
        .mem_instr  (mem_instr),
        .mem_mask   (mem_mask),
        .mem_scb_id (mem_scb_id),
        .cdb_valid  (cdb_valid),
        .cdb_warp   (cdb_warp),
        .cdb_addr   (cdb_addr),
        .cdb_data   (cdb_data),
        .cdb_instr  (cdb_instr),
        .cdb_mask   (cdb_mask),
        .cdb_scb_id (cdb_scb_id)
    );

    warp_regfile i_regfile (
        .clk       (clk),
        .reset     (reset),
        .cdb_valid (cdb_valid),
        .cdb_warp  (cdb_warp),
        .cdb_addr  (cdb_addr),
        .cdb_data  (cdb_data),
        .cdb_mask  (cdb_mask),
        .rd_warp   (rd_warp),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    warp_scoreboard i_scoreboard (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_warp   (issue_warp),
        .issue_dst    (issue_dst),
        .issue_scb_id (issue_scb_id),
        .cdb_valid    (cdb_valid),
        .cdb_warp     (cdb_warp),
        .cdb_scb_id   (cdb_scb_id),
        .issue_hazard (issue_hazard),
        .scb_busy     (scb_busy)
    );

endmodule

`default_nettype wire

//--- verif/wb_checker.sv
`default_nettype none

module wb_checker (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                alu_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                          alu_warp,
    input  wire [cdb_pkg::DST_W-1:0]                           alu_dst,
    input  wire [cdb_pkg::DATA_W-1:0]                          alu_data,
    input  wire [cdb_pkg::INSTR_W-1:0]                         alu_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]                       alu_mask,
    input  wire [cdb_pkg::SCB_W-1:0]                           alu_scb_id,
    input  wire                                                mem_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                          mem_warp,
    input  wire [cdb_pkg::DST_W-1:0]                           mem_dst,
    input  wire [cdb_pkg::DATA_W-1:0]                          mem_data,
    input  wire [cdb_pkg::INSTR_W-1:0]                         mem_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]                       mem_mask,
    input  wire [cdb_pkg::SCB_W-1:0]                           mem_scb_id,
    input  wire                                                issue_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                          issue_warp,
    input  wire [cdb_pkg::REG_W-1:0]                           issue_dst,
    input  wire [cdb_pkg::SCB_W-1:0]                           issue_scb_id,
    input  wire [cdb_pkg::WARP_W-1:0]                          rd_warp,
    input  wire [cdb_pkg::REG_W-1:0]                           rd_addr,
    input  wire [cdb_pkg::DATA_W-1:0]                          rd_data,
    input  wire                                                cdb_valid,
    input  wire [cdb_pkg::WARP_W-1:0]                          cdb_warp,
    input  wire [cdb_pkg::REG_W-1:0]                           cdb_addr,
    input  wire [cdb_pkg::DATA_W-1:0]                          cdb_data,
    input  wire [cdb_pkg::INSTR_W-1:0]                         cdb_instr,
    input  wire [cdb_pkg::NUM_LANES-1:0]                       cdb_mask,
    input  wire [cdb_pkg::SCB_W-1:0]                           cdb_scb_id,
    input  wire                                                alu_stall,
    input  wire                                                mem_stall,
    input  wire                                                issue_hazard,
    input  wire [cdb_pkg::NUM_WARPS*cdb_pkg::SCB_ENTRIES-1:0]  scb_busy,
    output int                                                 errors,
    output int                                                 bcast_count
);

    import cdb_pkg::*;

    localparam int NUM_ENT = NUM_WARPS * SCB_ENTRIES;

    int err_total   = 0;
    int bcast_total = 0;

    assign errors      = err_total;
    assign bcast_count = bcast_total;

    // Arbitration model.
    logic forced;
    int   lost_run;

    // Shadow register file and scoreboard.
    logic [DATA_W-1:0]  shadow_regs [NUM_WARPS*NUM_REGS];
    logic [NUM_ENT-1:0] shadow_busy;
    logic [REG_W-1:0]   shadow_dst [NUM_ENT];

    // The broadcast expected in the cycle after a grant.
    logic                 exp_valid;
    logic [WARP_W-1:0]    exp_warp;
    logic [REG_W-1:0]     exp_addr;
    logic [DATA_W-1:0]    exp_data;
    logic [INSTR_W-1:0]   exp_instr;
    logic [NUM_LANES-1:0] exp_mask;
    logic [SCB_W-1:0]     exp_scb_id;

    // ==============================
    // Reference functions
    // ==============================

    function automatic cdb_src_e model_grant(input logic a, input logic m, input logic frc);
        if (a && m)
            return frc ? SRC_MEM : SRC_ALU;
        if (a)
            return SRC_ALU;
        if (m)
            return SRC_MEM;
        return SRC_NONE;
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_val,
                                                      input logic [DATA_W-1:0] new_val,
                                                      input logic [NUM_LANES-1:0] mask);
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if (mask[l])
                res[l*LANE_W +: LANE_W] = new_val[l*LANE_W +: LANE_W];
        end
        return res;
    endfunction

    function automatic logic model_hazard(input logic [WARP_W-1:0] warp,
                                          input logic [REG_W-1:0] dst);
        logic hit;
        int   idx;
        hit = 1'b0;
        for (int e = 0; e < SCB_ENTRIES; e++)
        begin
            idx = int'(warp) * SCB_ENTRIES + e;
            if (shadow_busy[idx] && (shadow_dst[idx] == dst))
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            err_total++;
            $display("ERROR time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    // ==============================
    // Per-cycle comparison
    // ==============================

    always @(posedge clk)
    begin
        cdb_src_e                g;
        logic                    collide;
        logic [WARP_W+REG_W-1:0] wi;
        if (reset)
        begin
            forced      = 1'b0;
            lost_run    = 0;
            exp_valid   = 1'b0;
            shadow_busy = '0;
            for (int r = 0; r < NUM_WARPS * NUM_REGS; r++)
                shadow_regs[r] = '0;
        end
        else
        begin
            check_value("cdb_valid", cdb_valid, exp_valid);
            if (exp_valid)
            begin
                check_value("cdb_warp", cdb_warp, exp_warp);
                check_value("cdb_addr", cdb_addr, exp_addr);
                check_value("cdb_data", cdb_data, exp_data);
                check_value("cdb_instr", cdb_instr, exp_instr);
                check_value("cdb_mask", cdb_mask, exp_mask);
                check_value("cdb_scb_id", cdb_scb_id, exp_scb_id);
            end
            if (cdb_valid)
                bcast_total++;

            check_value("rd_data", rd_data, shadow_regs[{rd_warp, rd_addr}]);
            check_value("scb_busy", scb_busy, shadow_busy);
            check_value("issue_hazard", issue_hazard,
                        issue_valid && model_hazard(issue_warp, issue_dst));

            collide = alu_valid && mem_valid;
            g       = model_grant(alu_valid, mem_valid, forced);
            check_value("alu_stall", alu_stall, collide && (g == SRC_MEM));
            check_value("mem_stall", mem_stall, collide && (g == SRC_ALU));

            // The broadcast seen this cycle lands on this edge.
            if (exp_valid)
            begin
                wi = {exp_warp, exp_addr};
                shadow_regs[wi] = merge_lanes(shadow_regs[wi], exp_data, exp_mask);
                shadow_busy[{exp_warp, exp_scb_id}] = 1'b0;
            end
            if (issue_valid)
            begin
                shadow_busy[{issue_warp, issue_scb_id}] = 1'b1;
                shadow_dst[{issue_warp, issue_scb_id}]  = issue_dst;
            end

            if (g == SRC_MEM)
                lost_run = 0;
            else if (collide)
                lost_run = lost_run + 1;
            if (lost_run == STARVE_LIMIT)
                forced = 1'b1;
            else if (g == SRC_MEM)
                forced = 1'b0;

            exp_valid = (g != SRC_NONE);
            if (g == SRC_MEM)
            begin
                exp_warp   = mem_warp;
                exp_addr   = mem_dst[REG_W-1:0];
                exp_data   = mem_data;
                exp_instr  = mem_instr;
                exp_mask   = mem_mask;
                exp_scb_id = mem_scb_id;
            end
            else if (g == SRC_ALU)
            begin
                exp_warp   = alu_warp;
                exp_addr   = alu_dst[REG_W-1:0];
                exp_data   = alu_data;
                exp_instr  = alu_instr;
                exp_mask   = alu_mask;
                exp_scb_id = alu_scb_id;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_writeback.sv
`default_nettype none

module tb_writeback;

    import cdb_pkg::*;

    localparam int NUM_ENT    = NUM_WARPS * SCB_ENTRIES;
    localparam int WAIT_LIMIT = 40;

    logic                          clk;
    logic                          reset;
    logic                          alu_valid;
    logic [WARP_W-1:0]             alu_warp;
    logic [DST_W-1:0]              alu_dst;
    logic [DATA_W-1:0]             alu_data;
    logic [INSTR_W-1:0]            alu_instr;
    logic [NUM_LANES-1:0]          alu_mask;
    logic [SCB_W-1:0]              alu_scb_id;
    logic                          mem_valid;
    logic [WARP_W-1:0]             mem_warp;
    logic [DST_W-1:0]              mem_dst;
    logic [DATA_W-1:0]             mem_data;
    logic [INSTR_W-1:0]            mem_instr;
    logic [NUM_LANES-1:0]          mem_mask;
    logic [SCB_W-1:0]              mem_scb_id;
    logic                          issue_valid;
    logic [WARP_W-1:0]             issue_warp;
    logic [REG_W-1:0]              issue_dst;
    logic [SCB_W-1:0]              issue_scb_id;
    logic [WARP_W-1:0]             rd_warp;
    logic [REG_W-1:0]              rd_addr;
    logic [DATA_W-1:0]             rd_data;
    logic                          cdb_valid;
    logic [WARP_W-1:0]             cdb_warp;
    logic [REG_W-1:0]              cdb_addr;
    logic [DATA_W-1:0]             cdb_data;
    logic [INSTR_W-1:0]            cdb_instr;
    logic [NUM_LANES-1:0]          cdb_mask;
    logic [SCB_W-1:0]              cdb_scb_id;
    logic                          alu_stall;
    logic                          mem_stall;
    logic                          issue_hazard;
    logic [NUM_ENT-1:0]            scb_busy;

    int checker_errors;
    int bcast_count;
    int fail_count = 0;
    int sent_count = 0;

    // Entries reserved by the stimulus, with the destination given at issue.
    logic [NUM_ENT-1:0] tb_busy;
    logic [REG_W-1:0]   ent_dst [NUM_ENT];

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    writeback_top i_dut (.*);

    wb_checker i_checker (
        .errors      (checker_errors),
        .bcast_count (bcast_count),
        .*
    );

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic end_run;
        int total;
        total = fail_count + checker_errors;
        $display("Run complete: %0d checker errors, %0d other errors, %0d sent, %0d broadcast",
                 checker_errors, fail_count, sent_count, bcast_count);
        if (total == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    task automatic apply_reset;
        reset       = 1'b1;
        alu_valid   = 1'b0;
        mem_valid   = 1'b0;
        issue_valid = 1'b0;
        repeat (4) @(negedge clk);
        reset   = 1'b0;
        tb_busy = '0;
    endtask

    task automatic reserve_entry(input int ent, input logic [REG_W-1:0] dst);
        issue_valid  = 1'b1;
        issue_warp   = WARP_W'(ent / SCB_ENTRIES);
        issue_scb_id = SCB_W'(ent % SCB_ENTRIES);
        issue_dst    = dst;
        ent_dst[ent] = dst;
        tb_busy[ent] = 1'b1;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic point_read(input int ent);
        rd_warp = WARP_W'(ent / SCB_ENTRIES);
        rd_addr = ent_dst[ent];
    endtask

    // Offers one result and holds it until the unit is no longer stalled.
    task automatic send_result(input logic use_mem, input int ent);
        logic [DATA_W-1:0]    data;
        logic [NUM_LANES-1:0] mask;
        logic [DST_W-1:0]     dst;
        logic [INSTR_W-1:0]   instr;
        logic                 held;
        int                   cycles;
        for (int l = 0; l < NUM_LANES; l++)
            data[l*LANE_W +: LANE_W] = $urandom;
        mask  = NUM_LANES'($urandom);
        dst   = {(DST_W-REG_W)'($urandom), ent_dst[ent]};
        instr = $urandom;
        if (use_mem)
        begin
            mem_valid  = 1'b1;
            mem_warp   = WARP_W'(ent / SCB_ENTRIES);
            mem_scb_id = SCB_W'(ent % SCB_ENTRIES);
            mem_dst    = dst;
            mem_data   = data;
            mem_instr  = instr;
            mem_mask   = mask;
        end
        else
        begin
            alu_valid  = 1'b1;
            alu_warp   = WARP_W'(ent / SCB_ENTRIES);
            alu_scb_id = SCB_W'(ent % SCB_ENTRIES);
            alu_dst    = dst;
            alu_data   = data;
            alu_instr  = instr;
            alu_mask   = mask;
        end
        cycles = 0;
        held   = 1'b1;
        while (held)
        begin
            @(posedge clk);
            held = use_mem ? mem_stall : alu_stall;
            @(negedge clk);
            cycles++;
            if (held && cycles > WAIT_LIMIT)
            begin
                $display("Timeout: the %s result for entry %0d was never granted",
                         use_mem ? "MEM" : "ALU", ent);
                fail_count++;
                end_run();
            end
        end
        if (use_mem)
            mem_valid = 1'b0;
        else
            alu_valid = 1'b0;
        tb_busy[ent] = 1'b0;
        sent_count++;
    endtask

    task automatic wait_broadcast;
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!cdb_valid)
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
            begin
                $display("Timeout: no broadcast appeared on the CDB");
                fail_count++;
                end_run();
            end
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        int ent;
        void'($urandom(32'hd9d732ff));
        {alu_valid, alu_warp, alu_dst, alu_data, alu_instr, alu_mask, alu_scb_id} = '0;
        {mem_valid, mem_warp, mem_dst, mem_data, mem_instr, mem_mask, mem_scb_id} = '0;
        {issue_valid, issue_warp, issue_dst, issue_scb_id} = '0;
        rd_warp = '0;
        rd_addr = '0;
        tb_busy = '0;
        apply_reset();

        // One unit at a time.
        reserve_entry(0, REG_W'($urandom));
        reserve_entry(1, REG_W'($urandom));
        send_result(1'b0, 0);
        wait_broadcast();
        send_result(1'b1, 1);
        wait_broadcast();
        repeat (3) @(negedge clk);

        // Lane-masked writes, read back through the port.
        for (int k = 2; k < 10; k++)
        begin
            reserve_entry(k, REG_W'($urandom));
            point_read(k);
            send_result(1'(k % 2), k);
            wait_broadcast();
            repeat (2) @(negedge clk);
        end

        // Both units compete for the bus for many cycles.
        for (int k = 10; k < NUM_ENT; k++)
            reserve_entry(k, REG_W'($urandom));
        fork
            for (int k = 10; k < 21; k++)
                send_result(1'b0, k);
            for (int k = 21; k < NUM_ENT; k++)
                send_result(1'b1, k);
        join
        repeat (4) @(negedge clk);

        // Random issues into two warps so that destinations collide.
        repeat (16)
        begin
            ent = int'($urandom_range(7, 0));
            if (tb_busy[ent])
                @(negedge clk);
            else
                reserve_entry(ent, REG_W'($urandom_range(3, 0)));
        end
        for (int k = 0; k < 8; k++)
        begin
            if (tb_busy[k])
            begin
                send_result(1'(k % 2), k);
                wait_broadcast();
            end
        end
        repeat (3) @(negedge clk);

        // Reset while entries are pending and registers hold data.
        for (int k = 0; k < 4; k++)
            reserve_entry(k, REG_W'($urandom));
        point_read(0);
        send_result(1'b1, 0);
        wait_broadcast();
        apply_reset();
        for (int r = 0; r < NUM_WARPS * NUM_REGS; r++)
        begin
            rd_warp = WARP_W'(r / NUM_REGS);
            rd_addr = REG_W'(r % NUM_REGS);
            @(negedge clk);
        end
        reserve_entry(6, REG_W'($urandom));
        point_read(6);
        send_result(1'b0, 6);
        wait_broadcast();
        repeat (3) @(negedge clk);

        if (sent_count != bcast_count)
        begin
            $display("Result count mismatch: %0d results granted but %0d broadcasts seen",
                     sent_count, bcast_count);
            fail_count++;
        end
        end_run();
    end

endmodule

`default_nettype wire

//--- writeback.f
design/cdb_pkg.sv
design/cdb_grant_fsm.sv
design/starve_counter.sv
design/cdb_select.sv
design/warp_regfile.sv
design/warp_scoreboard.sv
design/writeback_top.sv
verif/wb_checker.sv
verif/tb_writeback.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_writeback
FILELIST  = writeback.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
